//--- rtl/vp_clock_enables.sv
module vp_clock_enables #(
	parameter int CPU_DIV_NTSC = 8,
	parameter int CPU_DIV_PAL  = 12,
	parameter int VDC_DIV_NTSC = 6,
	parameter int VDC_DIV_PAL  = 10
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic pal_mode_i,
	output logic cpu_en_o,
	output logic vdc_en_o
);

	// Counter widths sized for the longer period
	localparam int CPU_MAX = (CPU_DIV_PAL > CPU_DIV_NTSC) ? CPU_DIV_PAL : CPU_DIV_NTSC;
	localparam int VDC_MAX = (VDC_DIV_PAL > VDC_DIV_NTSC) ? VDC_DIV_PAL : VDC_DIV_NTSC;
	localparam int CPU_W   = $clog2(CPU_MAX);
	localparam int VDC_W   = $clog2(VDC_MAX);

	logic [CPU_W-1:0] cpu_cnt;
	logic [CPU_W-1:0] cpu_top;
	logic [VDC_W-1:0] vdc_cnt;
	logic [VDC_W-1:0] vdc_top;

	// Last count of each period for the current standard
	assign cpu_top = pal_mode_i ? CPU_W'(CPU_DIV_PAL - 1) : CPU_W'(CPU_DIV_NTSC - 1);
	assign vdc_top = pal_mode_i ? VDC_W'(VDC_DIV_PAL - 1) : VDC_W'(VDC_DIV_NTSC - 1);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cpu_cnt  <= '0;
			vdc_cnt  <= '0;
			cpu_en_o <= 1'b0;
			vdc_en_o <= 1'b0;
		end else begin
			// CPU divider, pulse on wrap
			if (cpu_cnt >= cpu_top) begin
				cpu_cnt  <= '0;
				cpu_en_o <= 1'b1;
			end else begin
				cpu_cnt  <= cpu_cnt + CPU_W'(1);
				cpu_en_o <= 1'b0;
			end
			// VDC divider, also the pixel rate
			if (vdc_cnt >= vdc_top) begin
				vdc_cnt  <= '0;
				vdc_en_o <= 1'b1;
			end else begin
				vdc_cnt  <= vdc_cnt + VDC_W'(1);
				vdc_en_o <= 1'b0;
			end
		end
	end

	// Enables are single-cycle pulses
	a_cpu_en_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		cpu_en_o |=> !cpu_en_o);
	a_vdc_en_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		vdc_en_o |=> !vdc_en_o);

endmodule

//--- rtl/vp_io_top.sv
module vp_io_top #(
	parameter int CPU_DIV_NTSC = 8,
	parameter int CPU_DIV_PAL  = 12,
	parameter int VDC_DIV_NTSC = 6,
	parameter int VDC_DIV_PAL  = 10,
	parameter int TRIM_LEFT    = 46,
	parameter int TRIM_RIGHT   = 367
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               pal_mode_i,
	input  logic               pal_palette_i,
	input  logic               trim_i,
	input  vp_pkg::ps2_event_t ps2_key_i,
	input  vp_pkg::joy_t       joy_a_i,
	input  vp_pkg::joy_t       joy_b_i,
	input  vp_pkg::vdc_pixel_t pixel_i,
	input  logic               hsync_n_i,
	input  logic               hblank_i,
	output logic               cpu_en_o,
	output logic               vdc_en_o,
	output logic               key_ready_o,
	output vp_pkg::ascii_t     key_ascii_o,
	output logic               key_released_o,
	output vp_pkg::rgb_t       rgb_o,
	output logic               hblank_o
);

	import vp_pkg::*;

	// Between key stages
	logic      ps2_chg;
	scancode_t scancode;
	logic      ps2_released;
	logic      joy_chg;
	numpad_t   numpad;

	//////////////////////////////////////////////////
	// Clock path
	//////////////////////////////////////////////////

	vp_clock_enables #(
		.CPU_DIV_NTSC (CPU_DIV_NTSC),
		.CPU_DIV_PAL  (CPU_DIV_PAL),
		.VDC_DIV_NTSC (VDC_DIV_NTSC),
		.VDC_DIV_PAL  (VDC_DIV_PAL)
	) u_clock_enables (
		.clk_sys    (clk_sys),
		.reset      (reset),
		.pal_mode_i (pal_mode_i),
		.cpu_en_o   (cpu_en_o),
		.vdc_en_o   (vdc_en_o)
	);

	//////////////////////////////////////////////////
	// Key path
	//////////////////////////////////////////////////

	vp_key_capture u_key_capture (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_key_i      (ps2_key_i),
		.joy_a_i        (joy_a_i),
		.joy_b_i        (joy_b_i),
		.ps2_chg_o      (ps2_chg),
		.scancode_o     (scancode),
		.ps2_released_o (ps2_released),
		.joy_chg_o      (joy_chg),
		.numpad_o       (numpad)
	);

	vp_key_translate u_key_translate (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ps2_chg_i      (ps2_chg),
		.scancode_i     (scancode),
		.ps2_released_i (ps2_released),
		.joy_chg_i      (joy_chg),
		.numpad_i       (numpad),
		.key_ready_o    (key_ready_o),
		.key_ascii_o    (key_ascii_o),
		.key_released_o (key_released_o)
	);

	// Pixel stage runs on the VDC enable
	vp_video_color #(
		.TRIM_LEFT  (TRIM_LEFT),
		.TRIM_RIGHT (TRIM_RIGHT)
	) u_video_color (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.vdc_en_i      (vdc_en_o),
		.pixel_i       (pixel_i),
		.hsync_n_i     (hsync_n_i),
		.hblank_i      (hblank_i),
		.pal_palette_i (pal_palette_i),
		.trim_i        (trim_i),
		.rgb_o         (rgb_o),
		.hblank_o      (hblank_o)
	);

endmodule

//--- rtl/vp_key_capture.sv
module vp_key_capture (
	input  logic               clk_sys,
	input  logic               reset,
	input  vp_pkg::ps2_event_t ps2_key_i,
	input  vp_pkg::joy_t       joy_a_i,
	input  vp_pkg::joy_t       joy_b_i,
	output logic               ps2_chg_o,
	output vp_pkg::scancode_t  scancode_o,
	output logic               ps2_released_o,
	output logic               joy_chg_o,
	output vp_pkg::numpad_t    numpad_o
);

	import vp_pkg::*;

	logic    toggle_q;
	numpad_t pad_q;
	numpad_t pad_now;
	logic    toggle_diff;

	// Both pads act as one keypad
	assign pad_now = joy_a_i[JOY_PAD_HI:JOY_PAD_LO] | joy_b_i[JOY_PAD_HI:JOY_PAD_LO];

	// New host event when the toggle flips
	assign toggle_diff = (ps2_key_i[PS2_TOGGLE] != toggle_q);

	//////////////////////////////////////////////////
	// Change detection
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q  <= 1'b0;
			pad_q     <= '0;
			ps2_chg_o <= 1'b0;
			joy_chg_o <= 1'b0;
		end else begin
			toggle_q  <= ps2_key_i[PS2_TOGGLE];
			pad_q     <= pad_now;
			ps2_chg_o <= toggle_diff;
			joy_chg_o <= (pad_now != pad_q);
		end
	end

	// Event data, held between PS/2 events
	always_ff @(posedge clk_sys) begin
		if (toggle_diff) begin
			scancode_o     <= ps2_key_i[8:0];
			ps2_released_o <= ~ps2_key_i[PS2_PRESSED];
		end
		numpad_o <= pad_now;
	end

	// Host must not flip the toggle on back-to-back cycles
	a_ps2_chg_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		ps2_chg_o |=> !ps2_chg_o);

endmodule

//--- rtl/vp_key_translate.sv
module vp_key_translate (
	input  logic              clk_sys,
	input  logic              reset,
	input  logic              ps2_chg_i,
	input  vp_pkg::scancode_t scancode_i,
	input  logic              ps2_released_i,
	input  logic              joy_chg_i,
	input  vp_pkg::numpad_t   numpad_i,
	output logic              key_ready_o,
	output vp_pkg::ascii_t    key_ascii_o,
	output logic              key_released_o
);

	import vp_pkg::*;

	// Pad bit order, lowest bit is digit one
	localparam ascii_t PAD_DIGITS [10] = '{"1", "2", "3", "4", "5", "6", "7", "8", "9", "0"};

	ascii_t ps2_ascii;
	ascii_t pad_ascii;
	ascii_t last_digit;
	logic   pad_empty;

	// Table search, extended bit ignored
	function automatic ascii_t scan_to_ascii(input scancode_t code);
		ascii_t result;
		result = KEY_NONE;
		for (int i = 0; i < KEY_COUNT; i++) begin
			if (KEY_TABLE[i].code[7:0] == code[7:0]) begin
				result = KEY_TABLE[i].ascii;
			end
		end
		return result;
	endfunction

	// Lowest set bit wins, so scan from the top down
	function automatic ascii_t pad_to_ascii(input numpad_t pad);
		ascii_t result;
		result = KEY_NONE;
		for (int i = 9; i >= 0; i--) begin
			if (pad[i]) begin
				result = PAD_DIGITS[i];
			end
		end
		return result;
	endfunction

	assign ps2_ascii = scan_to_ascii(scancode_i);
	assign pad_ascii = pad_to_ascii(numpad_i);
	assign pad_empty = (numpad_i == '0);

	//////////////////////////////////////////////////
	// Event merge
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			key_ready_o <= 1'b0;
			last_digit  <= KEY_NONE;
		end else begin
			key_ready_o <= ps2_chg_i | joy_chg_i;
			// Remembered for the release of all pad buttons
			if (joy_chg_i && !pad_empty) begin
				last_digit <= pad_ascii;
			end
		end
	end

	// PS/2 has priority over the pad
	always_ff @(posedge clk_sys) begin
		if (ps2_chg_i) begin
			key_ascii_o    <= ps2_ascii;
			key_released_o <= ps2_released_i;
		end else if (joy_chg_i) begin
			key_ascii_o    <= pad_empty ? last_digit : pad_ascii;
			key_released_o <= pad_empty;
		end
	end

	// Pad events always reach the keymap as a digit, releases included
	a_pad_digit: assert property (@(posedge clk_sys) disable iff (reset)
		(joy_chg_i && !ps2_chg_i) |=> (key_ascii_o inside {[8'h30:8'h39]}));

endmodule

//--- rtl/vp_pkg.sv
package vp_pkg;

	//////////////////////////////////////////////////
	// Key and joystick types
	//////////////////////////////////////////////////

	typedef logic [7:0]  ascii_t;
	// Extended flag in bit 8
	typedef logic [8:0]  scancode_t;
	// Toggle, pressed, scancode
	typedef logic [10:0] ps2_event_t;
	// Digits 1 to 9, then 0
	typedef logic [9:0]  numpad_t;
	typedef logic [15:0] joy_t;

	// Host key word fields
	localparam int PS2_TOGGLE  = 10;
	localparam int PS2_PRESSED = 9;

	// Number pad field inside a joystick word
	localparam int JOY_PAD_LO = 6;
	localparam int JOY_PAD_HI = 15;

	//////////////////////////////////////////////////
	// Video types
	//////////////////////////////////////////////////

	// R, G, B, luma from MSB down
	typedef logic [3:0]  vdc_pixel_t;
	typedef logic [23:0] rgb_t;
	typedef logic [8:0]  hcount_t;

	// Calibrated colour sets, black first, white luma last
	localparam rgb_t PALETTE_NTSC [16] = '{
		24'h000000, 24'h676767, 24'h1a37be, 24'h5c80f6,
		24'h006d07, 24'h56c469, 24'h2aaabe, 24'h77e6eb,
		24'h790000, 24'hc75151, 24'h94309f, 24'hdc84e8,
		24'h77670b, 24'hc6b86a, 24'hcecece, 24'hffffff
	};

	localparam rgb_t PALETTE_PAL [16] = '{
		24'h000000, 24'h494949, 24'h0000b6, 24'h4949ff,
		24'h00b601, 24'h49ff49, 24'h00b6c9, 24'h49ffff,
		24'hb60000, 24'hff4949, 24'hb600b6, 24'hff49ff,
		24'hb6b600, 24'hffff49, 24'hb6b6b6, 24'hffffff
	};

	//////////////////////////////////////////////////
	// Scancode table
	//////////////////////////////////////////////////

	typedef struct packed {
		scancode_t code;
		ascii_t    ascii;
	} key_entry_t;

	localparam ascii_t KEY_NONE  = 8'h00;
	localparam int     KEY_COUNT = 46;

	// Bit 8 of each code is a don't care
	localparam key_entry_t KEY_TABLE [KEY_COUNT] = '{
		'{9'h016, "1"}, '{9'h01e, "2"}, '{9'h026, "3"}, '{9'h025, "4"}, '{9'h02e, "5"},
		'{9'h036, "6"}, '{9'h03d, "7"}, '{9'h03e, "8"}, '{9'h046, "9"}, '{9'h045, "0"},
		'{9'h01c, "a"}, '{9'h032, "b"}, '{9'h021, "c"}, '{9'h023, "d"}, '{9'h024, "e"},
		'{9'h02b, "f"}, '{9'h034, "g"}, '{9'h033, "h"}, '{9'h043, "i"}, '{9'h03b, "j"},
		'{9'h042, "k"}, '{9'h04b, "l"}, '{9'h03a, "m"}, '{9'h031, "n"}, '{9'h044, "o"},
		'{9'h04d, "p"}, '{9'h015, "q"}, '{9'h02d, "r"}, '{9'h01b, "s"}, '{9'h02c, "t"},
		'{9'h03c, "u"}, '{9'h02a, "v"}, '{9'h01d, "w"}, '{9'h022, "x"}, '{9'h035, "y"},
		'{9'h01a, "z"}, '{9'h029, " "},
		// Operators
		'{9'h079, "+"}, '{9'h07b, "-"}, '{9'h07c, "*"}, '{9'h04a, "/"}, '{9'h055, "="},
		// Yes, no, enter, backspace
		'{9'h01f, 8'h11}, '{9'h027, 8'h12}, '{9'h05a, 8'h0a}, '{9'h066, 8'h08}
	};

endpackage

//--- rtl/vp_video_color.sv
module vp_video_color #(
	parameter int TRIM_LEFT  = 46,
	parameter int TRIM_RIGHT = 367
) (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               vdc_en_i,
	input  vp_pkg::vdc_pixel_t pixel_i,
	input  logic               hsync_n_i,
	input  logic               hblank_i,
	input  logic               pal_palette_i,
	input  logic               trim_i,
	output vp_pkg::rgb_t       rgb_o,
	output logic               hblank_o
);

	import vp_pkg::*;

	logic    hsync_n_q;
	hcount_t hcount;
	logic    line_start;
	logic    in_border;
	rgb_t    color;

	// Colour lookup by the RGBL code
	assign color = pal_palette_i ? PALETTE_PAL[pixel_i] : PALETTE_NTSC[pixel_i];

	// Sync rising edge seen at pixel rate
	assign line_start = hsync_n_i && !hsync_n_q;

	// Outside the visible window
	assign in_border = (hcount <= hcount_t'(TRIM_LEFT)) ||
		(hcount >= hcount_t'(TRIM_RIGHT));

	//////////////////////////////////////////////////
	// Pixel counter
	//////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			hsync_n_q <= 1'b0;
			hcount    <= '0;
		end else if (vdc_en_i) begin
			hsync_n_q <= hsync_n_i;
			// Restart at each line
			if (line_start) begin
				hcount <= '0;
			end else begin
				hcount <= hcount + hcount_t'(1);
			end
		end
	end

	//////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////

	// Registered every system cycle, not only on pixel enables
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			rgb_o    <= '0;
			hblank_o <= 1'b1;
		end else begin
			rgb_o    <= color;
			// Trim widens blanking to hide overscan
			hblank_o <= trim_i ? in_border : hblank_i;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the videopac_io testbench with Verilator, run it, look for the pass line
verilator --binary --timing --assert --top-module tb_vp_io -f videopac_io.f \
	-Mdir obj_dir -o tb_vp_io &&
	out=$(./obj_dir/tb_vp_io) &&
	echo "$out" &&
	echo "$out" | grep -q "All checks passed" || exit 1

//--- verification/tb_vp_io.sv
module tb_vp_io;

	import vp_pkg::*;

	localparam int CLK_HALF     = 20;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 10;

	// Design constants, passed down to the DUT
	localparam int CPU_DIV_NTSC = 8;
	localparam int CPU_DIV_PAL  = 12;
	localparam int VDC_DIV_NTSC = 6;
	localparam int VDC_DIV_PAL  = 10;
	localparam int TRIM_LEFT    = 46;
	localparam int TRIM_RIGHT   = 367;

	// Cycle budget per test group
	localparam int RESET_BUDGET = 3 * (RESET_CYCLES + 2);
	localparam int CLOCK_BUDGET = 2 * 4 * (CPU_DIV_PAL + VDC_DIV_PAL);
	localparam int KEY_BUDGET   = 3 * 20;
	localparam int PIXEL_BUDGET = 16 + 8;
	// Whole visible line at NTSC pixel rate
	localparam int TRIM_BUDGET  = (TRIM_RIGHT + 8) * VDC_DIV_NTSC;
	localparam int CYCLE_LIMIT  =
		(RESET_BUDGET + CLOCK_BUDGET + KEY_BUDGET + PIXEL_BUDGET + TRIM_BUDGET) * 5 / 4;

	logic       clk_sys;
	logic       reset;
	logic       pal_mode_i;
	logic       pal_palette_i;
	logic       trim_i;
	ps2_event_t ps2_key_i;
	joy_t       joy_a_i;
	joy_t       joy_b_i;
	vdc_pixel_t pixel_i;
	logic       hsync_n_i;
	logic       hblank_i;
	logic       cpu_en_o;
	logic       vdc_en_o;
	logic       key_ready_o;
	ascii_t     key_ascii_o;
	logic       key_released_o;
	rgb_t       rgb_o;
	logic       hblank_o;

	// Bookkeeping
	string       cur_test;
	int          tests;
	int          checks;
	int          errors;
	int          err_base;
	int          cycle_count;
	logic [15:0] lfsr;
	logic        ps2_toggle;

	vp_io_top #(
		.CPU_DIV_NTSC (CPU_DIV_NTSC),
		.CPU_DIV_PAL  (CPU_DIV_PAL),
		.VDC_DIV_NTSC (VDC_DIV_NTSC),
		.VDC_DIV_PAL  (VDC_DIV_PAL),
		.TRIM_LEFT    (TRIM_LEFT),
		.TRIM_RIGHT   (TRIM_RIGHT)
	) u_vp_io_top (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.pal_mode_i     (pal_mode_i),
		.pal_palette_i  (pal_palette_i),
		.trim_i         (trim_i),
		.ps2_key_i      (ps2_key_i),
		.joy_a_i        (joy_a_i),
		.joy_b_i        (joy_b_i),
		.pixel_i        (pixel_i),
		.hsync_n_i      (hsync_n_i),
		.hblank_i       (hblank_i),
		.cpu_en_o       (cpu_en_o),
		.vdc_en_o       (vdc_en_o),
		.key_ready_o    (key_ready_o),
		.key_ascii_o    (key_ascii_o),
		.key_released_o (key_released_o),
		.rgb_o          (rgb_o),
		.hblank_o       (hblank_o)
	);

	initial begin
		clk_sys = 1'b0;
		forever #CLK_HALF clk_sys = ~clk_sys;
	end

	// Hard stop in case a wait never ends
	always @(posedge clk_sys) begin
		cycle_count++;
		if (cycle_count >= CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Checks failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	// Both drive and sample points sit just after the edge
	task automatic next_cycle();
		@(posedge clk_sys);
		#DRIVE_DELAY;
	endtask

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);
	endfunction

	// One LFSR step per bit
	task automatic draw_bits(input int n, output int unsigned val);
		val = 0;
		for (int i = 0; i < n; i++) begin
			val  = {val[30:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic apply_reset(input logic pal);
		reset      = 1'b1;
		pal_mode_i = pal;
		repeat (RESET_CYCLES) next_cycle();
		reset = 1'b0;
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		err_base = errors;
		tests++;
	endtask

	task automatic end_test();
		if (errors == err_base) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, errors - err_base);
		end
	endtask

	//////////////////////////////////////////////////
	// Compare tasks
	//////////////////////////////////////////////////

	task automatic compare_bit(input string what, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s %s: expected %0b, actual %0b", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_int(input string what, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("error %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_ascii(input string what, input ascii_t exp, input ascii_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	task automatic compare_rgb(input string what, input rgb_t exp, input rgb_t act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("error %s %s: expected %h, actual %h", cur_test, what, exp, act);
		end
	endtask

	//////////////////////////////////////////////////
	// Clock enables
	//////////////////////////////////////////////////

	function automatic logic enable_of(input bit use_vdc);
		return use_vdc ? vdc_en_o : cpu_en_o;
	endfunction

	// Returns cycles until the next pulse
	task automatic wait_enable(input bit use_vdc, output int cycles);
		cycles = 0;
		do begin
			next_cycle();
			cycles++;
		end while (!enable_of(use_vdc) && cycles < 64);
		if (!enable_of(use_vdc)) begin
			errors++;
			$display("%s: no enable pulse within 64 cycles", cur_test);
		end
	endtask

	task automatic check_gaps(input bit use_vdc, input int exp, input string what);
		int gap;
		wait_enable(use_vdc, gap);
		repeat (3) begin
			wait_enable(use_vdc, gap);
			compare_int(what, exp, gap);
		end
	endtask

	task automatic test_clock();
		start_test("clock_enables");
		check_gaps(1'b0, CPU_DIV_NTSC, "cpu gap ntsc");
		check_gaps(1'b1, VDC_DIV_NTSC, "vdc gap ntsc");
		// Mode only changes under reset
		apply_reset(1'b1);
		check_gaps(1'b0, CPU_DIV_PAL, "cpu gap pal");
		check_gaps(1'b1, VDC_DIV_PAL, "vdc gap pal");
		apply_reset(1'b0);
		end_test();
	endtask

	//////////////////////////////////////////////////
	// Key path
	//////////////////////////////////////////////////

	// Ready lands two edges after the input change, for one cycle
	task automatic expect_key(input ascii_t exp_ascii, input logic exp_rel);
		next_cycle();
		compare_bit("ready early", 1'b0, key_ready_o);
		next_cycle();
		compare_bit("ready", 1'b1, key_ready_o);
		compare_ascii("ascii", exp_ascii, key_ascii_o);
		compare_bit("released", exp_rel, key_released_o);
		next_cycle();
		compare_bit("ready width", 1'b0, key_ready_o);
	endtask

	task automatic send_ps2(input scancode_t code, input logic pressed, input ascii_t exp);
		ps2_toggle = ~ps2_toggle;
		ps2_key_i  = {ps2_toggle, pressed, code};
		expect_key(exp, ~pressed);
	endtask

	// Pad sits in bits 15 to 6 of a joystick word
	function automatic joy_t pad_word(input numpad_t pad);
		return {pad, 6'b000000};
	endfunction

	task automatic test_ps2_keys();
		int unsigned idx;
		int unsigned ext;
		int unsigned press;
		scancode_t   code;
		start_test("ps2_keys");
		for (int k = 0; k < 10; k++) begin
			draw_bits(6, idx);
			idx = idx % KEY_COUNT;
			draw_bits(1, ext);
			draw_bits(1, press);
			// Extended bit must not change the lookup
			code = {ext[0], KEY_TABLE[idx].code[7:0]};
			send_ps2(code, press[0], KEY_TABLE[idx].ascii);
		end
		send_ps2(9'h0ff, 1'b1, KEY_NONE);
		end_test();
	endtask

	task automatic test_pad();
		start_test("numpad");
		// Digits 3 and 5, lowest wins
		joy_a_i = pad_word(10'b0000010100);
		expect_key("3", 1'b0);
		joy_a_i = '0;
		joy_b_i = pad_word(10'b1000000000);
		expect_key("0", 1'b0);
		// Digit 7 on the other stick, 0 still held
		joy_a_i = pad_word(10'b0001000000);
		expect_key("7", 1'b0);
		joy_a_i = '0;
		joy_b_i = '0;
		expect_key("7", 1'b1);
		end_test();
	endtask

	task automatic test_priority();
		start_test("ps2_priority");
		ps2_toggle = ~ps2_toggle;
		ps2_key_i  = {ps2_toggle, 1'b1, 9'h015};
		joy_a_i    = pad_word(10'b0000000010);
		expect_key("q", 1'b0);
		// Release repeats the pad digit
		joy_a_i = '0;
		expect_key("2", 1'b1);
		end_test();
	endtask

	//////////////////////////////////////////////////
	// Video path
	//////////////////////////////////////////////////

	task automatic test_palette();
		int unsigned pix;
		int unsigned pal;
		rgb_t        exp;
		start_test("palette");
		for (int k = 0; k < 16; k++) begin
			draw_bits(4, pix);
			draw_bits(1, pal);
			pixel_i       = pix[3:0];
			pal_palette_i = pal[0];
			exp = pal[0] ? PALETTE_PAL[pix[3:0]] : PALETTE_NTSC[pix[3:0]];
			next_cycle();
			compare_rgb("rgb", exp, rgb_o);
		end
		end_test();
	endtask

	task automatic test_trim();
		int          cnt;
		int          waited;
		logic        en;
		logic        exp;
		int unsigned b;
		start_test("hblank_trim");
		trim_i    = 1'b1;
		hsync_n_i = 1'b0;
		wait_enable(1'b1, waited);
		wait_enable(1'b1, waited);
		// Sync rises during an enable cycle, so the count restarts at its edge
		hsync_n_i = 1'b1;
		next_cycle();
		cnt = 0;
		while (cnt < TRIM_RIGHT + 4) begin
			exp = (cnt <= TRIM_LEFT) || (cnt >= TRIM_RIGHT);
			en  = vdc_en_o;
			next_cycle();
			compare_bit("hblank trimmed", exp, hblank_o);
			if (en) begin
				cnt++;
			end
		end
		// Untrimmed blanking passes straight through
		trim_i = 1'b0;
		for (int k = 0; k < 8; k++) begin
			draw_bits(1, b);
			hblank_i = b[0];
			next_cycle();
			compare_bit("hblank follow", b[0], hblank_o);
		end
		end_test();
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		reset         = 1'b1;
		pal_mode_i    = 1'b0;
		pal_palette_i = 1'b0;
		trim_i        = 1'b0;
		ps2_key_i     = '0;
		joy_a_i       = '0;
		joy_b_i       = '0;
		pixel_i       = '0;
		hsync_n_i     = 1'b0;
		hblank_i      = 1'b0;
		ps2_toggle    = 1'b0;
		lfsr          = 16'd86;
		tests         = 0;
		checks        = 0;
		errors        = 0;
		cycle_count   = 0;
		apply_reset(1'b0);
		test_clock();
		test_ps2_keys();
		test_pad();
		test_priority();
		test_palette();
		test_trim();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

endmodule

//--- videopac_io.f
rtl/vp_pkg.sv
rtl/vp_clock_enables.sv
rtl/vp_key_capture.sv
rtl/vp_key_translate.sv
rtl/vp_video_color.sv
rtl/vp_io_top.sv
verification/tb_vp_io.sv
